// ==== filelist.f ====
verilog/vram_pkg.sv
verilog/dual_port_vram.sv
verilog/vram_bus_fsm.sv
verilog/activity_led.sv
verilog/video_memory_unit.sv
test/video_memory_unit_checker.sv
test/video_memory_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module video_memory_unit_tb \
    -f filelist.f

# Let checker assertions keep counting so the testbench reaches its report
status=0
output=$(./obj_dir/Vvideo_memory_unit_tb +verilator+error+limit+1000 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'Done: no errors'; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// ==== test/video_memory_unit_checker.sv ====
`default_nettype none

module video_memory_unit_checker (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [vram_pkg::BUS_ADDR_WIDTH-1:0] bus_addr,
    input  logic                                bus_we,
    input  logic                                bus_start,
    input  logic                                bus_done,
    input  logic                                led_gpu
);
    import vram_pkg::*;

    // Failed assertions so far, read by the testbench at the end
    int unsigned assert_failures = 0;

    vram_region_t                   region;
    logic [REGION_OFFSET_WIDTH-1:0] offset;
    logic                           in_range;
    logic                           accept;
    // Bus free to take a start
    logic                           idle;
    // Access in flight is an in-range write
    logic                           write_in_range;

    assign region = vram_region_t'(bus_addr[BUS_ADDR_WIDTH-1 -: REGION_SEL_WIDTH]);
    assign offset = bus_addr[REGION_OFFSET_WIDTH-1:0];
    assign accept = bus_start && idle;

    always_comb begin
        case (region)
            region_vram32:  in_range = offset < REGION_OFFSET_WIDTH'(VRAM32_WORDS);
            region_vram8:   in_range = offset < REGION_OFFSET_WIDTH'(VRAM8_WORDS);
            region_vramspr: in_range = offset < REGION_OFFSET_WIDTH'(VRAMSPR_WORDS);
            default:        in_range = 1'b0;
        endcase
    end

    // Busy from accept until done
    always_ff @(posedge clk) begin
        if (reset) begin
            idle           <= 1'b1;
            write_in_range <= 1'b0;
        end else if (accept) begin
            idle           <= 1'b0;
            write_in_range <= bus_we && in_range;
        end else if (bus_done) begin
            idle <= 1'b1;
        end
    end

    done_latency: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##1 !bus_done ##1 bus_done)
        else begin
            assert_failures++;
            $error("bus_done missing 2 cycles after an accepted start");
        end

    done_single: assert property (@(posedge clk) disable iff (reset)
        bus_done |=> !bus_done)
        else begin
            assert_failures++;
            $error("bus_done held high for two cycles");
        end

    // No disable here, this one looks at reset itself
    reset_quiet: assert property (@(posedge clk)
        reset |=> (!bus_done && !led_gpu))
        else begin
            assert_failures++;
            $error("bus_done or led_gpu high right after reset");
        end

    led_on_write: assert property (@(posedge clk) disable iff (reset)
        (bus_done && write_in_range) |-> led_gpu)
        else begin
            assert_failures++;
            $error("led_gpu low at the done of an in-range write");
        end

endmodule

bind video_memory_unit video_memory_unit_checker checker_inst (
    .clk       (clk),
    .reset     (reset),
    .bus_addr  (bus_addr),
    .bus_we    (bus_we),
    .bus_start (bus_start),
    .bus_done  (bus_done),
    .led_gpu   (led_gpu)
);

`default_nettype wire

// ==== test/video_memory_unit_tb.sv ====
`default_nettype none

module video_memory_unit_tb;
    import vram_pkg::*;

    // Region codes in the top two address bits
    localparam logic [1:0] sel_vram32  = 2'd0;
    localparam logic [1:0] sel_vram8   = 2'd1;
    localparam logic [1:0] sel_vramspr = 2'd2;
    localparam logic [1:0] sel_none    = 2'd3;

    localparam int random_writes = 24;
    // Bus access budget from issue to return with slack
    localparam int access_cycles = 4;
    localparam int transactions  = 4 * random_writes + 40;
    // Two LED hold waits dominate
    localparam int max_cycles = 16 + transactions * access_cycles
                              + 2 * (LED_HOLD_CYCLES + 2) + 100;

    logic                           clk;
    logic                           reset;
    logic [BUS_ADDR_WIDTH-1:0]      bus_addr;
    logic [BUS_DATA_WIDTH-1:0]      bus_data;
    logic                           bus_we;
    logic                           bus_start;
    logic [BUS_DATA_WIDTH-1:0]      bus_q;
    logic                           bus_done;
    logic [REGION_OFFSET_WIDTH-1:0] vram32_gpu_addr;
    logic [REGION_OFFSET_WIDTH-1:0] vram8_gpu_addr;
    logic [REGION_OFFSET_WIDTH-1:0] vramspr_gpu_addr;
    logic [VRAM32_WIDTH-1:0]        vram32_gpu_q;
    logic [VRAM8_WIDTH-1:0]         vram8_gpu_q;
    logic [VRAMSPR_WIDTH-1:0]       vramspr_gpu_q;
    logic                           led_gpu;

    // Absent reference entries read as zero
    logic [VRAM32_WIDTH-1:0]  ref32 [int];
    logic [VRAM8_WIDTH-1:0]   ref8 [int];
    logic [VRAMSPR_WIDTH-1:0] refspr [int];

    integer seed = 32'ha8160f2c;
    int     cycles = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    video_memory_unit video_memory_unit_inst (
        .clk              (clk),
        .reset            (reset),
        .bus_addr         (bus_addr),
        .bus_data         (bus_data),
        .bus_we           (bus_we),
        .bus_start        (bus_start),
        .bus_q            (bus_q),
        .bus_done         (bus_done),
        .vram32_gpu_addr  (vram32_gpu_addr),
        .vram8_gpu_addr   (vram8_gpu_addr),
        .vramspr_gpu_addr (vramspr_gpu_addr),
        .vram32_gpu_q     (vram32_gpu_q),
        .vram8_gpu_q      (vram8_gpu_q),
        .vramspr_gpu_q    (vramspr_gpu_q),
        .led_gpu          (led_gpu)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hard stop in case a done never comes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int region_words(input logic [1:0] sel);
        case (sel)
            sel_vram32:  return VRAM32_WORDS;
            sel_vram8:   return VRAM8_WORDS;
            sel_vramspr: return VRAMSPR_WORDS;
            default:     return 0;
        endcase
    endfunction

    // Low bits kept by a region and none for region_none
    function automatic logic [31:0] width_mask(input logic [1:0] sel);
        int bits;
        case (sel)
            sel_vram32:  bits = VRAM32_WIDTH;
            sel_vram8:   bits = VRAM8_WIDTH;
            sel_vramspr: bits = VRAMSPR_WIDTH;
            default:     bits = 0;
        endcase
        return ~(32'hFFFF_FFFF << bits);
    endfunction

    function automatic logic [BUS_ADDR_WIDTH-1:0] make_addr(input logic [1:0] sel,
                                                            input int offset);
        return {sel, REGION_OFFSET_WIDTH'(offset)};
    endfunction

    function automatic logic [31:0] model_read(input logic [1:0] sel, input int offset);
        logic [31:0] value;
        value = '0;
        case (sel)
            sel_vram32:  if (ref32.exists(offset)) value = ref32[offset];
            sel_vram8:   if (ref8.exists(offset)) value = 32'(ref8[offset]);
            sel_vramspr: if (refspr.exists(offset)) value = 32'(refspr[offset]);
            default:     value = '0;
        endcase
        return value;
    endfunction

    // Zero-extended GPU port output of one region
    function automatic logic [31:0] gpu_data(input logic [1:0] sel);
        logic [31:0] value;
        case (sel)
            sel_vram32:  value = vram32_gpu_q;
            sel_vram8:   value = 32'(vram8_gpu_q);
            default:     value = 32'(vramspr_gpu_q);
        endcase
        return value;
    endfunction

    function automatic int random_offset(input int words);
        return int'($unsigned($random(seed)) % words);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    // One bus access; latency counts edges from issue to done
    task automatic bus_access(
        input  logic [BUS_ADDR_WIDTH-1:0] addr,
        input  logic [BUS_DATA_WIDTH-1:0] data,
        input  logic                      we,
        output logic [BUS_DATA_WIDTH-1:0] q,
        output int                        latency
    );
        @(posedge clk);
        bus_addr  <= addr;
        bus_data  <= data;
        bus_we    <= we;
        bus_start <= 1'b1;
        latency = 0;
        // Done sampled mid-cycle
        do begin
            @(posedge clk);
            bus_start <= 1'b0;
            latency++;
            @(negedge clk);
        end while (!bus_done);
        q = bus_q;
    endtask

    task automatic write_word(input string name, input logic [1:0] sel, input int offset,
                              input logic [BUS_DATA_WIDTH-1:0] data);
        logic [BUS_DATA_WIDTH-1:0] q;
        logic [BUS_DATA_WIDTH-1:0] stored;
        int                        latency;
        stored = (offset < region_words(sel)) ? (data & width_mask(sel)) : '0;
        bus_access(make_addr(sel, offset), data, 1'b1, q, latency);
        check_value({name, " write latency"}, 32'd2, 32'(latency));
        check_value({name, " write echo"}, stored, q);
        if (offset < region_words(sel)) begin
            case (sel)
                sel_vram32:  ref32[offset] = stored;
                sel_vram8:   ref8[offset] = VRAM8_WIDTH'(stored);
                sel_vramspr: refspr[offset] = VRAMSPR_WIDTH'(stored);
                default:     ;
            endcase
        end
    endtask

    task automatic read_word(input string name, input logic [1:0] sel, input int offset);
        logic [BUS_DATA_WIDTH-1:0] q;
        int                        latency;
        bus_access(make_addr(sel, offset), '0, 1'b0, q, latency);
        check_value({name, " read latency"}, 32'd2, 32'(latency));
        check_value({name, " read data"}, model_read(sel, offset), q);
    endtask

    // Address applied on one edge and data checked after the next
    task automatic gpu_read(input string name, input logic [1:0] sel, input int offset);
        int old_offset;
        @(posedge clk);
        case (sel)
            sel_vram32: begin
                old_offset = int'(vram32_gpu_addr);
                vram32_gpu_addr <= REGION_OFFSET_WIDTH'(offset);
            end
            sel_vram8: begin
                old_offset = int'(vram8_gpu_addr);
                vram8_gpu_addr <= REGION_OFFSET_WIDTH'(offset);
            end
            default: begin
                old_offset = int'(vramspr_gpu_addr);
                vramspr_gpu_addr <= REGION_OFFSET_WIDTH'(offset);
            end
        endcase
        // Old address still on the output until the next edge
        @(negedge clk);
        check_value({name, " before edge"}, model_read(sel, old_offset), gpu_data(sel));
        @(posedge clk);
        @(negedge clk);
        check_value(name, model_read(sel, offset), gpu_data(sel));
    endtask

    initial begin
        logic [31:0] q;
        int          done_count;
        int          first_done;
        reset            = 1'b1;
        bus_addr         = '0;
        bus_data         = '0;
        bus_we           = 1'b0;
        bus_start        = 1'b0;
        vram32_gpu_addr  = '0;
        vram8_gpu_addr   = '0;
        vramspr_gpu_addr = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        start_test();
        for (int i = 0; i < random_writes; i++) begin
            write_word("vram32_random", sel_vram32, random_offset(VRAM32_WORDS), $random(seed));
        end
        foreach (ref32[k]) read_word("vram32_random", sel_vram32, k);
        report_test("vram32_random");

        // Full 32-bit data into the narrow RAMs
        start_test();
        for (int i = 0; i < random_writes / 2; i++) begin
            write_word("narrow_width", sel_vram8, random_offset(VRAM8_WORDS), $random(seed));
            write_word("narrow_width", sel_vramspr, random_offset(VRAMSPR_WORDS), $random(seed));
        end
        write_word("narrow_width", sel_vram8, VRAM8_WORDS - 1, 32'hDEAD_BEEF);
        write_word("narrow_width", sel_vramspr, VRAMSPR_WORDS - 1, 32'h1234_5FFF);
        foreach (ref8[k]) read_word("narrow_width", sel_vram8, k);
        foreach (refspr[k]) read_word("narrow_width", sel_vramspr, k);
        report_test("narrow_width");

        start_test();
        write_word("gpu_port", sel_vram32, 100, 32'hCAFE_0100);
        write_word("gpu_port", sel_vram8, 4000, 32'h0000_00A5);
        write_word("gpu_port", sel_vramspr, 200, 32'h0000_0123);
        gpu_read("gpu_port vram32", sel_vram32, 100);
        gpu_read("gpu_port vram8", sel_vram8, 4000);
        gpu_read("gpu_port vramspr", sel_vramspr, 200);
        report_test("gpu_port");

        start_test();
        write_word("out_of_range", sel_vram32, 0, 32'h1111_0000);
        write_word("out_of_range", sel_vram32, 32, 32'h2222_0020);
        write_word("out_of_range", sel_none, 0, 32'hFFFF_FFFF);
        write_word("out_of_range", sel_none, 32, 32'hFFFF_FFFF);
        write_word("out_of_range", sel_vram32, VRAM32_WORDS, 32'hFFFF_FFFF);
        read_word("out_of_range", sel_none, 0);
        read_word("out_of_range", sel_vram32, VRAM32_WORDS);
        read_word("out_of_range", sel_vram32, 0);
        read_word("out_of_range", sel_vram32, 32);
        report_test("out_of_range");

        // Second start lands in st_access and must be dropped
        start_test();
        write_word("ignored_start", sel_vram32, 5, 32'h5555_0005);
        write_word("ignored_start", sel_vram32, 6, 32'h6666_0006);
        @(posedge clk);
        bus_addr  <= make_addr(sel_vram32, 5);
        bus_we    <= 1'b0;
        bus_start <= 1'b1;
        @(posedge clk);
        bus_addr  <= make_addr(sel_vram32, 6);
        @(posedge clk);
        bus_start <= 1'b0;
        done_count = 0;
        first_done = 0;
        q = '0;
        for (int c = 2; c <= 8; c++) begin
            @(negedge clk);
            if (bus_done) begin
                done_count++;
                if (first_done == 0) begin
                    first_done = c;
                    q = bus_q;
                end
            end
            @(posedge clk);
        end
        check_value("ignored_start done count", 32'd1, 32'(done_count));
        check_value("ignored_start done latency", 32'd2, 32'(first_done));
        check_value("ignored_start read data", model_read(sel_vram32, 5), q);
        report_test("ignored_start");

        start_test();
        repeat (LED_HOLD_CYCLES + 2) @(posedge clk);
        @(negedge clk);
        check_value("led_activity idle", 32'd0, 32'(led_gpu));
        for (int i = 0; i < 4; i++) begin
            read_word("led_activity", sel_vram32, 32 * i);
            check_value("led_activity during read", 32'd0, 32'(led_gpu));
        end
        write_word("led_activity", sel_vramspr, 7, 32'h0000_0155);
        check_value("led_activity at write done", 32'd1, 32'(led_gpu));
        // Write issued 2 edges before done so the LED goes dark at hold plus 2
        repeat (LED_HOLD_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("led_activity last lit cycle", 32'd1, 32'(led_gpu));
        @(posedge clk);
        @(negedge clk);
        check_value("led_activity after hold", 32'd0, 32'(led_gpu));
        report_test("led_activity");

        $display("summary: %0d tests, %0d failed, %0d mismatches, %0d checker failures",
                 tests_run, tests_failed, errors,
                 video_memory_unit_inst.checker_inst.assert_failures);
        if (errors == 0 && video_memory_unit_inst.checker_inst.assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/activity_led.sv ====
`default_nettype none

module activity_led #(
    parameter int hold_cycles = vram_pkg::LED_HOLD_CYCLES
) (
    input  logic clk,
    input  logic reset,
    input  logic activity,
    output logic led
);

    // Enough bits to hold the reload value
    localparam int count_width = $clog2(hold_cycles + 1);

    logic [count_width-1:0] count;

    // Reload on every activity cycle
    // Otherwise run down to zero and stay there
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (activity) begin
            count <= count_width'(hold_cycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Lit while the timer is running
    assign led = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/dual_port_vram.sv ====
`default_nettype none

module dual_port_vram #(
    parameter int width = 32,
    parameter int words = 1024
) (
    input  logic                                    clk,
    input  logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] cpu_addr,
    input  logic [width-1:0]                        cpu_d,
    input  logic                                    cpu_we,
    input  logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] gpu_addr,
    output logic [width-1:0]                        cpu_q,
    output logic [width-1:0]                        gpu_q
);
    import vram_pkg::*;

    // Index width that just covers the word count
    localparam int addr_bits = $clog2(words);

    logic [width-1:0] mem [0:words-1];

    logic                 cpu_hit;
    logic                 gpu_hit;
    logic [addr_bits-1:0] cpu_index;
    logic [addr_bits-1:0] gpu_index;

    // Addresses past the last word never touch the array
    assign cpu_hit   = cpu_addr < REGION_OFFSET_WIDTH'(words);
    assign gpu_hit   = gpu_addr < REGION_OFFSET_WIDTH'(words);
    assign cpu_index = cpu_addr[addr_bits-1:0];
    assign gpu_index = gpu_addr[addr_bits-1:0];

    // Contents start cleared
    initial begin
        for (int i = 0; i < words; i++) begin
            mem[i] = '0;
        end
    end

    // CPU port, write-first so a write returns what was stored
    always_ff @(posedge clk) begin
        if (cpu_we && cpu_hit) begin
            mem[cpu_index] <= cpu_d;
            cpu_q <= cpu_d;
        end else begin
            cpu_q <= cpu_hit ? mem[cpu_index] : '0;
        end
    end

    // GPU port, read only
    always_ff @(posedge clk) begin
        gpu_q <= gpu_hit ? mem[gpu_index] : '0;
    end

endmodule

`default_nettype wire

// ==== verilog/video_memory_unit.sv ====
`default_nettype none

module video_memory_unit (
    input  logic                                     clk,
    input  logic                                     reset,
    // CPU bus
    input  logic [vram_pkg::BUS_ADDR_WIDTH-1:0]      bus_addr,
    input  logic [vram_pkg::BUS_DATA_WIDTH-1:0]      bus_data,
    input  logic                                     bus_we,
    input  logic                                     bus_start,
    output logic [vram_pkg::BUS_DATA_WIDTH-1:0]      bus_q,
    output logic                                     bus_done,
    // GPU read ports
    input  logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] vram32_gpu_addr,
    input  logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] vram8_gpu_addr,
    input  logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] vramspr_gpu_addr,
    output logic [vram_pkg::VRAM32_WIDTH-1:0]        vram32_gpu_q,
    output logic [vram_pkg::VRAM8_WIDTH-1:0]         vram8_gpu_q,
    output logic [vram_pkg::VRAMSPR_WIDTH-1:0]       vramspr_gpu_q,
    // GPU activity
    output logic                                     led_gpu
);
    import vram_pkg::*;

    // Shared CPU side of the three RAMs
    logic [REGION_OFFSET_WIDTH-1:0] ram_addr;
    logic [BUS_DATA_WIDTH-1:0]      ram_d;

    logic vram32_we;
    logic vram8_we;
    logic vramspr_we;

    logic [VRAM32_WIDTH-1:0]  vram32_cpu_q;
    logic [VRAM8_WIDTH-1:0]   vram8_cpu_q;
    logic [VRAMSPR_WIDTH-1:0] vramspr_cpu_q;

    logic wr_strobe;

    // Bus access sequencer
    vram_bus_fsm vram_bus_fsm_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_addr   (bus_addr),
        .bus_data   (bus_data),
        .bus_we     (bus_we),
        .bus_start  (bus_start),
        .vram32_q   (vram32_cpu_q),
        .vram8_q    (vram8_cpu_q),
        .vramspr_q  (vramspr_cpu_q),
        .bus_q      (bus_q),
        .bus_done   (bus_done),
        .ram_addr   (ram_addr),
        .ram_d      (ram_d),
        .vram32_we  (vram32_we),
        .vram8_we   (vram8_we),
        .vramspr_we (vramspr_we),
        .wr_strobe  (wr_strobe)
    );

    // Tile and palette memory
    dual_port_vram #(
        .width (VRAM32_WIDTH),
        .words (VRAM32_WORDS)
    ) vram32_inst (
        .clk      (clk),
        .cpu_addr (ram_addr),
        .cpu_d    (ram_d[VRAM32_WIDTH-1:0]),
        .cpu_we   (vram32_we),
        .gpu_addr (vram32_gpu_addr),
        .cpu_q    (vram32_cpu_q),
        .gpu_q    (vram32_gpu_q)
    );

    // Pattern memory, low byte of the bus data
    dual_port_vram #(
        .width (VRAM8_WIDTH),
        .words (VRAM8_WORDS)
    ) vram8_inst (
        .clk      (clk),
        .cpu_addr (ram_addr),
        .cpu_d    (ram_d[VRAM8_WIDTH-1:0]),
        .cpu_we   (vram8_we),
        .gpu_addr (vram8_gpu_addr),
        .cpu_q    (vram8_cpu_q),
        .gpu_q    (vram8_gpu_q)
    );

    // Sprite table, low 9 bits
    dual_port_vram #(
        .width (VRAMSPR_WIDTH),
        .words (VRAMSPR_WORDS)
    ) vramspr_inst (
        .clk      (clk),
        .cpu_addr (ram_addr),
        .cpu_d    (ram_d[VRAMSPR_WIDTH-1:0]),
        .cpu_we   (vramspr_we),
        .gpu_addr (vramspr_gpu_addr),
        .cpu_q    (vramspr_cpu_q),
        .gpu_q    (vramspr_gpu_q)
    );

    // Stretch write activity into a visible blink
    activity_led #(
        .hold_cycles (LED_HOLD_CYCLES)
    ) activity_led_inst (
        .clk      (clk),
        .reset    (reset),
        .activity (wr_strobe),
        .led      (led_gpu)
    );

endmodule

`default_nettype wire

// ==== verilog/vram_bus_fsm.sv ====
`default_nettype none

module vram_bus_fsm (
    input  logic                                     clk,
    input  logic                                     reset,
    // CPU bus
    input  logic [vram_pkg::BUS_ADDR_WIDTH-1:0]      bus_addr,
    input  logic [vram_pkg::BUS_DATA_WIDTH-1:0]      bus_data,
    input  logic                                     bus_we,
    input  logic                                     bus_start,
    // CPU read data from the RAMs
    input  logic [vram_pkg::VRAM32_WIDTH-1:0]        vram32_q,
    input  logic [vram_pkg::VRAM8_WIDTH-1:0]         vram8_q,
    input  logic [vram_pkg::VRAMSPR_WIDTH-1:0]       vramspr_q,
    output logic [vram_pkg::BUS_DATA_WIDTH-1:0]      bus_q,
    output logic                                     bus_done,
    // Shared CPU port of the RAMs
    output logic [vram_pkg::REGION_OFFSET_WIDTH-1:0] ram_addr,
    output logic [vram_pkg::BUS_DATA_WIDTH-1:0]      ram_d,
    output logic                                     vram32_we,
    output logic                                     vram8_we,
    output logic                                     vramspr_we,
    // Write activity for the GPU LED
    output logic                                     wr_strobe
);
    import vram_pkg::*;

    bus_state_t state;
    bus_state_t state_next;

    // Decode of the incoming address
    vram_region_t                   start_region;
    logic [REGION_OFFSET_WIDTH-1:0] start_offset;
    logic                           start_in_range;
    logic                           accept;

    // Registered request
    vram_region_t                   req_region;
    logic [REGION_OFFSET_WIDTH-1:0] req_offset;
    logic [BUS_DATA_WIDTH-1:0]      req_data;
    logic                           req_we;
    logic                           req_in_range;

    logic write_now;

    // Offset limit per region; region_none never matches
    function automatic logic offset_in_range(
        input vram_region_t                   region,
        input logic [REGION_OFFSET_WIDTH-1:0] offset
    );
        logic hit;
        case (region)
            region_vram32:  hit = offset < REGION_OFFSET_WIDTH'(VRAM32_WORDS);
            region_vram8:   hit = offset < REGION_OFFSET_WIDTH'(VRAM8_WORDS);
            region_vramspr: hit = offset < REGION_OFFSET_WIDTH'(VRAMSPR_WORDS);
            default:        hit = 1'b0;
        endcase
        return hit;
    endfunction

    assign start_region   = vram_region_t'(bus_addr[BUS_ADDR_WIDTH-1 -: REGION_SEL_WIDTH]);
    assign start_offset   = bus_addr[REGION_OFFSET_WIDTH-1:0];
    assign start_in_range = offset_in_range(start_region, start_offset);

    // Starts outside idle are dropped
    assign accept = bus_start && (state == st_idle);

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (bus_start) state_next = st_access;
            st_access: state_next = st_done;
            st_done:   state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            req_we <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                req_we <= bus_we;
            end
        end
    end

    // Request payload, only meaningful after an accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_region   <= start_region;
            req_offset   <= start_offset;
            req_data     <= bus_data;
            req_in_range <= start_in_range;
        end
    end

    // RAM port straight from the request
    assign ram_addr = req_offset;
    assign ram_d    = req_data;

    // Single write cycle, only in range
    assign write_now  = (state == st_access) && req_we && req_in_range;
    assign vram32_we  = write_now && (req_region == region_vram32);
    assign vram8_we   = write_now && (req_region == region_vram8);
    assign vramspr_we = write_now && (req_region == region_vramspr);
    assign wr_strobe  = write_now;

    assign bus_done = (state == st_done);

    // Read mux, zero-extended; misses read as zero
    always_comb begin
        bus_q = '0;
        if (req_in_range) begin
            case (req_region)
                region_vram32:  bus_q = BUS_DATA_WIDTH'(vram32_q);
                region_vram8:   bus_q = BUS_DATA_WIDTH'(vram8_q);
                region_vramspr: bus_q = BUS_DATA_WIDTH'(vramspr_q);
                default:        bus_q = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vram_pkg.sv ====
`default_nettype none

package vram_pkg;

    // CPU bus widths
    localparam int BUS_ADDR_WIDTH = 16;
    localparam int BUS_DATA_WIDTH = 32;

    // Offset inside one region, also the RAM address width
    localparam int REGION_OFFSET_WIDTH = 14;

    // Width of the region select field at the top of the bus address
    localparam int REGION_SEL_WIDTH = BUS_ADDR_WIDTH - REGION_OFFSET_WIDTH;

    // Tile and palette table, full bus width
    localparam int VRAM32_WIDTH = 32;
    localparam int VRAM32_WORDS = 1056;

    // Pattern and color table, byte wide
    localparam int VRAM8_WIDTH = 8;
    localparam int VRAM8_WORDS = 8194;

    // Sprite attribute table, 9 bits so X positions reach past 255
    localparam int VRAMSPR_WIDTH = 9;
    localparam int VRAMSPR_WORDS = 256;

    // GPU LED stretch, in clk cycles
    localparam int LED_HOLD_CYCLES = 1000;

    // Region decode, straight from the top two address bits
    typedef enum logic [REGION_SEL_WIDTH-1:0] {
        region_vram32  = 2'd0,
        region_vram8   = 2'd1,
        region_vramspr = 2'd2,
        // Unmapped quarter of the bus space
        region_none    = 2'd3
    } vram_region_t;

    // Access sequence, one cycle per state
    typedef enum logic [1:0] {
        // Waiting for a start pulse
        st_idle,
        // RAM address and write enable driven
        st_access,
        // Read data back from the RAM, done pulse
        st_done
    } bus_state_t;

endpackage

`default_nettype wire
